// File: logic/rvv_pkg.sv
package rvv_pkg;

    // core widths
    localparam int insn_width     = 32;
    localparam int vlen           = 64;
    localparam int elem_width     = 8;
    localparam int num_lanes      = vlen / elem_width;
    localparam int num_vec        = 32;
    localparam int reg_addr_width = 5;
    localparam int mem_addr_width = 5;
    localparam int imm_width      = 5;

    // instruction field positions, msb and lsb of each
    localparam int funct6_msb = 31;
    localparam int funct6_lsb = 26;
    localparam int vs2_msb    = 24;
    localparam int vs2_lsb    = 20;
    // vs1, rs1 or the 5-bit immediate
    localparam int vs1_msb    = 19;
    localparam int vs1_lsb    = 15;
    localparam int minor_msb  = 14;
    localparam int minor_lsb  = 12;
    // vd for alu and loads, vs3 for stores
    localparam int vd_msb     = 11;
    localparam int vd_lsb     = 7;
    localparam int major_msb  = 6;
    localparam int major_lsb  = 0;

    typedef enum logic [6:0] {
        op_load   = 7'h07,
        op_store  = 7'h27,
        op_vector = 7'h57
    } opcode_major_e;

    // only the integer forms are kept
    typedef enum logic [2:0] {
        opivv = 3'h0,
        opivi = 3'h3
    } opcode_minor_e;

    typedef enum logic [5:0] {
        f_add = 6'h00,
        f_sub = 6'h02,
        f_and = 6'h09,
        f_or  = 6'h0a,
        f_xor = 6'h0b
    } alu_func_e;

    // decoded class of the instruction in the fetch register
    typedef enum logic [1:0] {
        iss_none,
        iss_alu,
        iss_load,
        iss_store
    } issue_kind_e;

endpackage

// File: logic/rvv_ctrl.sv
module rvv_ctrl
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [insn_width-1:0]     insn_in,
    input  logic                      insn_valid,
    input  logic                      alu_wr_valid,
    input  logic [reg_addr_width-1:0] alu_wr_dest,
    input  logic                      ld_wr_valid,
    input  logic [reg_addr_width-1:0] ld_wr_dest,
    input  logic                      load_busy,
    output logic                      proc_rdy,
    output logic [reg_addr_width-1:0] rd_addr_1,
    output logic [reg_addr_width-1:0] rd_addr_2,
    output logic [reg_addr_width-1:0] rd_addr_3,
    output logic                      alu_issue,
    output alu_func_e                 alu_func,
    output logic                      alu_use_imm,
    output logic [imm_width-1:0]      alu_imm,
    output logic [reg_addr_width-1:0] alu_dest,
    output logic                      ld_start,
    output logic                      st_start,
    output logic [mem_addr_width-1:0] mem_addr,
    output logic [reg_addr_width-1:0] ld_dest
);

    // fetch register
    logic                      fetch_valid;
    logic [insn_width-1:0]     fetch_insn;

    // decoded fields of the fetched instruction
    opcode_major_e             major;
    opcode_minor_e             minor;
    alu_func_e                 funct6;
    logic [reg_addr_width-1:0] vs1;
    logic [reg_addr_width-1:0] vs2;
    logic [reg_addr_width-1:0] vd;
    logic                      func_ok;
    issue_kind_e               kind;

    // one pending-write bit per vector register
    logic [num_vec-1:0]        busy_regs;
    logic [num_vec-1:0]        busy_next;
    logic                      hazard;
    logic                      issue_go;

    assign major  = opcode_major_e'(fetch_insn[major_msb:major_lsb]);
    assign minor  = opcode_minor_e'(fetch_insn[minor_msb:minor_lsb]);
    assign funct6 = alu_func_e'(fetch_insn[funct6_msb:funct6_lsb]);
    // vs1 doubles as rs1 and the immediate
    assign vs1    = fetch_insn[vs1_msb:vs1_lsb];
    assign vs2    = fetch_insn[vs2_msb:vs2_lsb];
    // vd doubles as the store source vs3
    assign vd     = fetch_insn[vd_msb:vd_lsb];

    // only the listed integer functions
    always_comb begin
        case (funct6)
            f_add, f_sub, f_and, f_or, f_xor: func_ok = 1'b1;
            default:                          func_ok = 1'b0;
        endcase
    end

    // anything unlisted retires as a no-op
    always_comb begin
        case (major)
            op_load:   kind = iss_load;
            op_store:  kind = iss_store;
            op_vector: kind = ((minor == opivv || minor == opivi) && func_ok) ?
                              iss_alu : iss_none;
            default:   kind = iss_none;
        endcase
    end

    // raw on sources, waw on the destination
    always_comb begin
        case (kind)
            iss_alu:   hazard = busy_regs[vs2] || busy_regs[vd] ||
                                (!alu_use_imm && busy_regs[vs1]);
            iss_load:  hazard = busy_regs[vd];
            iss_store: hazard = busy_regs[vd];
            default:   hazard = 1'b0;
        endcase
    end

    // nothing enters or leaves while a load is in flight
    assign proc_rdy = !load_busy && !(fetch_valid && hazard);
    assign issue_go = fetch_valid && !load_busy && !hazard;

    assign alu_issue = issue_go && (kind == iss_alu);
    assign ld_start  = issue_go && (kind == iss_load);
    assign st_start  = issue_go && (kind == iss_store);

    // regfile ports, read in the issue cycle
    assign rd_addr_1 = vs1;
    assign rd_addr_2 = vs2;
    assign rd_addr_3 = vd;

    assign alu_func    = funct6;
    assign alu_use_imm = (minor == opivi);
    assign alu_imm     = vs1;
    assign alu_dest    = vd;
    // rs1 used directly as the memory address
    assign mem_addr    = vs1;
    assign ld_dest     = vd;

    // fetch holds while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (proc_rdy) begin
            fetch_valid <= insn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_rdy && insn_valid) begin
            fetch_insn <= insn_in;
        end
    end

    always_comb begin
        busy_next = busy_regs;
        // write backs release their register
        if (alu_wr_valid) begin
            busy_next[alu_wr_dest] = 1'b0;
        end
        if (ld_wr_valid) begin
            busy_next[ld_wr_dest] = 1'b0;
        end
        // new destination claims its register
        if (alu_issue || ld_start) begin
            busy_next[vd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_regs <= '0;
        end else begin
            busy_regs <= busy_next;
        end
    end

endmodule

// File: logic/rvv_regfile.sv
module rvv_regfile
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [reg_addr_width-1:0] rd_addr_1,
    input  logic [reg_addr_width-1:0] rd_addr_2,
    input  logic [reg_addr_width-1:0] rd_addr_3,
    input  logic                      wr_en,
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [vlen-1:0]           wr_data,
    input  logic                      ld_en,
    input  logic [reg_addr_width-1:0] ld_addr,
    input  logic [vlen-1:0]           ld_data,
    output logic [vlen-1:0]           rd_data_1,
    output logic [vlen-1:0]           rd_data_2,
    output logic [vlen-1:0]           rd_data_3
);

    logic [vlen-1:0] regs [num_vec];

    // combinational reads, sampled in the issue cycle
    // port 1 feeds vs1, port 2 feeds vs2
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];
    // port 3 is the store source vs3
    assign rd_data_3 = regs[rd_addr_3];

    // alu and load write ports never hit the same register
    // scoreboard keeps them apart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_vec; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            // load write back
            if (ld_en) begin
                regs[ld_addr] <= ld_data;
            end
        end
    end

endmodule

// File: logic/rvv_alu.sv
module rvv_alu
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue,
    input  alu_func_e                 func,
    input  logic                      use_imm,
    input  logic [imm_width-1:0]      imm,
    input  logic [reg_addr_width-1:0] dest,
    input  logic [vlen-1:0]           vs1_data,
    input  logic [vlen-1:0]           vs2_data,
    output logic                      res_valid,
    output logic [vlen-1:0]           res_data,
    output logic [reg_addr_width-1:0] res_dest
);

    logic [elem_width-1:0] imm_ext;
    logic [vlen-1:0]       operand;
    logic [vlen-1:0]       res_next;

    // 5-bit immediate sign extended to one element
    assign imm_ext = {{(elem_width - imm_width){imm[imm_width-1]}}, imm};

    // .vi form puts the immediate in every lane
    assign operand = use_imm ? {num_lanes{imm_ext}} : vs1_data;

    // lanes independent, carries never cross an element
    // vs2 op operand, 8-bit wrap on add and sub
    always_comb begin
        res_next = vs2_data;
        for (int i = 0; i < num_lanes; i++) begin
            case (func)
                f_add: res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width] + operand[i*elem_width +: elem_width];
                f_sub: res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width] - operand[i*elem_width +: elem_width];
                f_and: res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width] & operand[i*elem_width +: elem_width];
                f_or:  res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width] | operand[i*elem_width +: elem_width];
                f_xor: res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width] ^ operand[i*elem_width +: elem_width];
                // ctrl only issues the listed functions
                default: res_next[i*elem_width +: elem_width] =
                    vs2_data[i*elem_width +: elem_width];
            endcase
        end
    end

    // result stage, write back one cycle later through the regfile
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res_data <= res_next;
            res_dest <= dest;
        end
    end

endmodule

// File: logic/rvv_mem_port.sv
module rvv_mem_port
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      st_start,
    input  logic                      ld_start,
    input  logic [mem_addr_width-1:0] addr,
    input  logic [reg_addr_width-1:0] ld_dest,
    input  logic [vlen-1:0]           st_data,
    input  logic [vlen-1:0]           mem_port_in,
    input  logic                      mem_port_valid_in,
    output logic [vlen-1:0]           mem_port_out,
    output logic [mem_addr_width-1:0] mem_port_addr_out,
    output logic                      mem_port_valid_out,
    output logic                      mem_port_ready_out,
    output logic                      ld_wr_valid,
    output logic [vlen-1:0]           ld_wr_data,
    output logic [reg_addr_width-1:0] ld_wr_dest,
    output logic                      load_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_data,
        st_write_back
    } ld_state_e;

    ld_state_e state;

    // load FSM
    // wait_data holds until memory answers, write_back is one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:       if (ld_start) state <= st_wait_data;
                st_wait_data:  if (mem_port_valid_in) state <= st_write_back;
                st_write_back: state <= st_idle;
                default:       state <= st_idle;
            endcase
        end
    end

    // ready stays up with a steady address until the data edge
    assign mem_port_ready_out = (state == st_wait_data);
    assign ld_wr_valid        = (state == st_write_back);
    assign load_busy          = (state != st_idle);

    // store pulse, no back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_port_valid_out <= 1'b0;
        end else begin
            mem_port_valid_out <= st_start;
        end
    end

    // shared address register
    // load and store never start together
    always_ff @(posedge clk) begin
        if (st_start || ld_start) begin
            mem_port_addr_out <= addr;
        end
        if (st_start) begin
            mem_port_out <= st_data;
        end
        if (ld_start) begin
            ld_wr_dest <= ld_dest;
        end
        // capture on the answering edge
        if (state == st_wait_data && mem_port_valid_in) begin
            ld_wr_data <= mem_port_in;
        end
    end

endmodule

// File: logic/rvv_core.sv
module rvv_core
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [insn_width-1:0]     insn_in,
    input  logic                      insn_valid,
    input  logic [vlen-1:0]           mem_port_in,
    input  logic                      mem_port_valid_in,
    output logic                      mem_port_ready_out,
    output logic [vlen-1:0]           mem_port_out,
    output logic [mem_addr_width-1:0] mem_port_addr_out,
    output logic                      mem_port_valid_out,
    output logic                      proc_rdy
);

    // regfile read side
    logic [reg_addr_width-1:0] rd_addr_1;
    logic [reg_addr_width-1:0] rd_addr_2;
    logic [reg_addr_width-1:0] rd_addr_3;
    logic [vlen-1:0]           rd_data_1;
    logic [vlen-1:0]           rd_data_2;
    logic [vlen-1:0]           rd_data_3;

    // alu issue
    logic                      alu_issue;
    alu_func_e                 alu_func;
    logic                      alu_use_imm;
    logic [imm_width-1:0]      alu_imm;
    logic [reg_addr_width-1:0] alu_dest;

    // alu result to regfile and scoreboard
    logic                      alu_res_valid;
    logic [vlen-1:0]           alu_res_data;
    logic [reg_addr_width-1:0] alu_res_dest;

    // memory side
    logic                      ld_start;
    logic                      st_start;
    logic [mem_addr_width-1:0] mem_addr;
    logic [reg_addr_width-1:0] ld_dest;
    logic                      ld_wr_valid;
    logic [vlen-1:0]           ld_wr_data;
    logic [reg_addr_width-1:0] ld_wr_dest;
    logic                      load_busy;

    rvv_ctrl rvv_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .insn_in      (insn_in),
        .insn_valid   (insn_valid),
        .alu_wr_valid (alu_res_valid),
        .alu_wr_dest  (alu_res_dest),
        .ld_wr_valid  (ld_wr_valid),
        .ld_wr_dest   (ld_wr_dest),
        .load_busy    (load_busy),
        .proc_rdy     (proc_rdy),
        .rd_addr_1    (rd_addr_1),
        .rd_addr_2    (rd_addr_2),
        .rd_addr_3    (rd_addr_3),
        .alu_issue    (alu_issue),
        .alu_func     (alu_func),
        .alu_use_imm  (alu_use_imm),
        .alu_imm      (alu_imm),
        .alu_dest     (alu_dest),
        .ld_start     (ld_start),
        .st_start     (st_start),
        .mem_addr     (mem_addr),
        .ld_dest      (ld_dest)
    );

    rvv_regfile rvv_regfile_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .rd_addr_3 (rd_addr_3),
        .wr_en     (alu_res_valid),
        .wr_addr   (alu_res_dest),
        .wr_data   (alu_res_data),
        .ld_en     (ld_wr_valid),
        .ld_addr   (ld_wr_dest),
        .ld_data   (ld_wr_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .rd_data_3 (rd_data_3)
    );

    rvv_alu rvv_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (alu_issue),
        .func      (alu_func),
        .use_imm   (alu_use_imm),
        .imm       (alu_imm),
        .dest      (alu_dest),
        .vs1_data  (rd_data_1),
        .vs2_data  (rd_data_2),
        .res_valid (alu_res_valid),
        .res_data  (alu_res_data),
        .res_dest  (alu_res_dest)
    );

    rvv_mem_port rvv_mem_port_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .st_start           (st_start),
        .ld_start           (ld_start),
        .addr               (mem_addr),
        .ld_dest            (ld_dest),
        .st_data            (rd_data_3),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .mem_port_ready_out (mem_port_ready_out),
        .ld_wr_valid        (ld_wr_valid),
        .ld_wr_data         (ld_wr_data),
        .ld_wr_dest         (ld_wr_dest),
        .load_busy          (load_busy)
    );

endmodule

// File: bench/rvv_core_properties.sv
module rvv_core_properties
    import rvv_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_port_valid_out,
    input  logic                      mem_port_ready_out,
    input  logic [mem_addr_width-1:0] mem_port_addr_out,
    input  logic                      mem_port_valid_in,
    input  logic                      proc_rdy
);
    timeunit 1ns;
    timeprecision 100ps;

    // store pulse and load request share the address bus
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_port_valid_out && mem_port_ready_out))
        else $error("store valid and load ready high in the same cycle");

    // load request holds until memory answers
    a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_port_ready_out && !mem_port_valid_in |=>
            mem_port_ready_out && $stable(mem_port_addr_out))
        else $error("load request dropped or address moved before data came back");

    // nothing issues during a load
    a_rdy_low_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        mem_port_ready_out |-> !proc_rdy)
        else $error("proc_rdy high while a load is outstanding");

    // first cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !mem_port_valid_out && !mem_port_ready_out)
        else $error("memory port valid outputs high right after reset");

endmodule

// File: bench/rvv_core_tb.sv
module rvv_core_tb
    import rvv_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                      clk;
    logic                      rst_n;
    logic [insn_width-1:0]     insn_in;
    logic                      insn_valid;
    logic [vlen-1:0]           mem_port_in;
    logic                      mem_port_valid_in;
    logic                      mem_port_ready_out;
    logic [vlen-1:0]           mem_port_out;
    logic [mem_addr_width-1:0] mem_port_addr_out;
    logic                      mem_port_valid_out;
    logic                      proc_rdy;

    // record = kind nibble, address byte, 64-bit data
    logic [75:0]               stim [128];
    logic [vlen-1:0]           mem [32];
    logic [insn_width-1:0]     insn_q [$];
    logic [mem_addr_width-1:0] exp_addr_q [$];
    logic [vlen-1:0]           exp_data_q [$];
    logic [31:0]               lfsr;
    int                        mismatch_count;
    int                        other_count;
    bit                        saw_stall;

    rvv_core rvv_core_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .insn_in            (insn_in),
        .insn_valid         (insn_valid),
        .mem_port_in        (mem_port_in),
        .mem_port_valid_in  (mem_port_valid_in),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_out       (mem_port_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_out (mem_port_valid_out),
        .proc_rdy           (proc_rdy)
    );

    bind rvv_core rvv_core_properties rvv_core_properties_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_port_valid_out (mem_port_valid_out),
        .mem_port_ready_out (mem_port_ready_out),
        .mem_port_addr_out  (mem_port_addr_out),
        .mem_port_valid_in  (mem_port_valid_in),
        .proc_rdy           (proc_rdy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // right-shift galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    function automatic void report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    endfunction

    task automatic abort_run(input string reason);
        other_count++;
        $display("%s at %0t", reason, $time);
        report_counts();
        $display("Regression failed");
        $finish;
    endtask

    task automatic load_stim();
        for (int i = 0; i < 128; i++) begin
            stim[i] = '0;
        end
        $readmemh("bench/rvv_stim.txt", stim);
        // background words carry their own address
        for (int a = 0; a < 32; a++) begin
            mem[a] = {8{3'b101, a[4:0]}};
        end
        for (int i = 0; i < 128; i++) begin
            case (stim[i][75:72])
                4'h1: mem[stim[i][68:64]] = stim[i][63:0];
                4'h2: insn_q.push_back(stim[i][31:0]);
                4'h3: begin
                    exp_addr_q.push_back(stim[i][68:64]);
                    exp_data_q.push_back(stim[i][63:0]);
                end
                default: ;
            endcase
        end
    endtask

    // called at a rising edge, returns at the accepting edge
    task automatic issue_insn(input logic [insn_width-1:0] insn);
        int cycles;
        insn_in    <= insn;
        insn_valid <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (proc_rdy !== 1'b1 && cycles < 500) begin
            saw_stall = 1'b1;
            cycles++;
            @(negedge clk);
        end
        if (cycles >= 500) begin
            abort_run("timeout waiting for proc_rdy to accept an instruction");
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic wait_stores_done();
        int cycles;
        cycles = 0;
        while (exp_data_q.size() != 0 && cycles < 2000) begin
            cycles++;
            @(negedge clk);
        end
        if (exp_data_q.size() != 0) begin
            abort_run("timeout waiting for the expected stores");
        end
    endtask

    // memory model, answers each load after 0 to 3 cycles
    initial begin : mem_responder
        logic [1:0] delay;
        forever begin
            @(negedge clk);
            if (mem_port_ready_out === 1'b1) begin
                delay = 2'd0;
                for (int i = 0; i < 2; i++) begin
                    lfsr  = galois_step(lfsr);
                    delay = {delay[0], lfsr[0]};
                end
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_port_valid_in <= 1'b1;
                mem_port_in       <= mem[mem_port_addr_out];
                @(posedge clk);
                mem_port_valid_in <= 1'b0;
            end
        end
    end

    // stores must come out in program order
    initial begin : store_checker
        forever begin
            @(negedge clk);
            if (mem_port_valid_out === 1'b1) begin
                mem[mem_port_addr_out] = mem_port_out;
                if (exp_data_q.size() == 0) begin
                    other_count++;
                    $display("store to address %0h with no store left to expect at %0t",
                             mem_port_addr_out, $time);
                end else begin
                    if (mem_port_addr_out !== exp_addr_q[0] ||
                        mem_port_out !== exp_data_q[0]) begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: store expected %0h:%h got %0h:%h", $time,
                                 exp_addr_q[0], exp_data_q[0], mem_port_addr_out, mem_port_out);
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
        end
    end

    initial begin : main_seq
        rst_n             = 1'b0;
        insn_in           = '0;
        insn_valid        = 1'b0;
        mem_port_in       = '0;
        mem_port_valid_in = 1'b0;
        lfsr              = 32'ha82e_2e81;
        mismatch_count    = 0;
        other_count       = 0;
        saw_stall         = 1'b0;
        load_stim();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (mem_port_valid_out !== 1'b0 || mem_port_ready_out !== 1'b0 || proc_rdy !== 1'b1) begin
            mismatch_count++;
            $display("MISMATCH at %0t: after reset valid_out=%b ready_out=%b proc_rdy=%b",
                     $time, mem_port_valid_out, mem_port_ready_out, proc_rdy);
        end
        @(posedge clk);
        // back to back, valid stays up between instructions
        foreach (insn_q[i]) begin
            issue_insn(insn_q[i]);
        end
        insn_valid <= 1'b0;
        wait_stores_done();
        if (!saw_stall) begin
            other_count++;
            $display("proc_rdy never went low during the instruction stream");
        end
        report_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: bench/rvv_stim.txt
// columns: kind (1 preload, 2 instruction, 3 expected store), address, 64-bit data
// instructions sit in the low 32 bits of the data column
// preload: a at 01, b at 02, c at 03
1_01_7f80ff01_33c00fa5
1_02_010101ff_4450f05a
1_03_deadbeef_01234567
// vle v1 (01), vle v2 (02), store v1 to 10
2_00_00000000_02008087
2_00_00000000_02010107
2_00_00000000_020800a7
// vv ops into v3, v3 = v1 op v2, each stored to 11..15
2_00_00000000_021101d7
2_00_00000000_020881a7
2_00_00000000_0a1101d7
2_00_00000000_020901a7
2_00_00000000_261101d7
2_00_00000000_020981a7
2_00_00000000_2a1101d7
2_00_00000000_020a01a7
2_00_00000000_2e1101d7
2_00_00000000_020a81a7
// vi ops into v4 from v1, imm 5, -3, 15, -16, stored to 16..19
2_00_00000000_0212b257
2_00_00000000_020b0227
2_00_00000000_021eb257
2_00_00000000_020b8227
2_00_00000000_2617b257
2_00_00000000_020c0227
2_00_00000000_2e183257
2_00_00000000_020c8227
// chain v10 = v1 + v2, v11 = v10 ^ v2, store v11 to 1a
2_00_00000000_02110557
2_00_00000000_2ea105d7
2_00_00000000_020d05a7
// vle v5 (03) then store v5 to 1b right away
2_00_00000000_02018287
2_00_00000000_020d82a7
// funct6 3f onto v1, then store v1 to 1c
2_00_00000000_fe2100d7
2_00_00000000_020e00a7
// expected stores in order
3_10_7f80ff01_33c00fa5
3_11_80810000_7710ffff
3_12_7e7ffe02_ef701f4b
3_13_01000101_00400000
3_14_7f81ffff_77d0ffff
3_15_7e81fefe_7790ffff
3_16_84850406_38c514aa
3_17_7c7dfcfe_30bd0ca2
3_18_0f000f01_03000f05
3_19_8f700ff1_c330ff55
3_1a_818001ff_33400fa5
3_1b_deadbeef_01234567
3_1c_7f80ff01_33c00fa5

// File: rvv_core.f
logic/rvv_pkg.sv
logic/rvv_ctrl.sv
logic/rvv_regfile.sv
logic/rvv_alu.sv
logic/rvv_mem_port.sv
logic/rvv_core.sv
bench/rvv_core_properties.sv
bench/rvv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvv_core_tb
FILELIST  ?= rvv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
